/* logic/uart_rx_pkg.sv */
package uart_rx_pkg;

    // ----------------------------------------
    // Frame format encodings
    // ----------------------------------------

    // Number of data bits in one character
    typedef enum logic [1:0] {
        DW_5BIT = 2'b00,
        DW_6BIT = 2'b01,
        DW_7BIT = 2'b10,
        DW_8BIT = 2'b11
    } data_width_e;

    // Any code with the upper bit set disables the parity bit
    typedef enum logic [1:0] {
        PAR_EVEN = 2'b00,
        PAR_ODD  = 2'b01,
        PAR_NONE = 2'b10
    } parity_mode_e;

    // Only code 01 selects two stop bits, every other code means one
    typedef enum logic [1:0] {
        SB_1BIT = 2'b00,
        SB_2BIT = 2'b01
    } stop_bits_e;

    // Receiver FSM states
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_SAMPLE,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

    // ----------------------------------------
    // Sizing constants
    // ----------------------------------------

    // Ticks per bit and the tick that lands in the middle of the start bit
    localparam int OVERSAMPLE = 16;
    localparam int TICK_W     = $clog2(OVERSAMPLE);
    localparam int MID_SAMPLE = 7;

    // Receive buffer geometry
    localparam int RX_BUF_DEPTH = 32;
    localparam int PTR_W        = $clog2(RX_BUF_DEPTH);
    localparam int LEVEL_W      = 6;
    localparam int RX_WORD_W    = 11;

    // The line rests high between frames
    localparam logic RX_LINE_IDLE = 1'b1;

    // Flag positions above the 8 data bits of a buffer word
    localparam int BIT_FRAME_ERR  = 8;
    localparam int BIT_PARITY_ERR = 9;
    localparam int BIT_OVERRUN    = 10;

endpackage : uart_rx_pkg

/* logic/rx_frame_if.sv */
`timescale 1ns/1ns

interface rx_frame_if;

    // One-cycle strobe marking the end of a received frame
    logic       frame_done;

    // Character right-aligned to the data width, upper bits zero
    logic [7:0] data;

    // Error flags, only meaningful while frame_done is high
    logic       frame_err;
    logic       parity_err;

    // The sampler produces a frame and never waits for the buffer
    modport sampler (
        output frame_done,
        output data,
        output frame_err,
        output parity_err
    );

    // The buffer consumes a frame in the cycle it is offered, or drops it
    modport buffer (
        input frame_done,
        input data,
        input frame_err,
        input parity_err
    );

endinterface : rx_frame_if

/* logic/rx_frame_sampler.sv */
`timescale 1ns/1ns

module rx_frame_sampler (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      enable_i,
    input  logic                      ov_baud_rt_i,
    input  logic                      rx_i,
    input  uart_rx_pkg::data_width_e  data_width_i,
    input  uart_rx_pkg::parity_mode_e parity_mode_i,
    input  uart_rx_pkg::stop_bits_e   stop_bits_number_i,
    output logic                      rx_idle_o,
    rx_frame_if.sampler               frame
);

    import uart_rx_pkg::*;

    // ----------------------------------------
    // State and counters
    // ----------------------------------------

    rx_state_e         state_q;
    logic [TICK_W-1:0] tick_cnt_q;
    logic [2:0]        bit_cnt_q;

    // Set once the first of two stop bits has been taken
    logic              stop_cnt_q;

    // Stays high only while every stop bit so far was sampled high
    logic              stop_ok_q;

    // Shift register for the data bits and the captured parity bit
    logic [7:0]        data_q;
    logic              parity_q;

    // Index of the last data bit for the selected width
    logic [2:0]        last_bit;
    assign last_bit = {1'b0, data_width_i} + 3'd4;

    // A tick that closes a full bit period, which is the middle of the bit
    logic bit_end;
    assign bit_end = ov_baud_rt_i && (tick_cnt_q == TICK_W'(OVERSAMPLE - 1));

    // The stop bit being sampled now is the final one of the frame
    logic last_stop;
    assign last_stop = (stop_bits_number_i != SB_2BIT) || stop_cnt_q;

    // ----------------------------------------
    // FSM
    // ----------------------------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= RX_IDLE;
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            stop_cnt_q <= 1'b0;
            stop_ok_q  <= 1'b1;
        end else begin
            // The tick counter wraps by itself since OVERSAMPLE is a power of two
            if (state_q != RX_IDLE && ov_baud_rt_i) begin
                tick_cnt_q <= tick_cnt_q + 1'b1;
            end

            case (state_q)
                RX_IDLE: begin
                    // A low line while enabled is taken as a start bit edge
                    if (rx_i != RX_LINE_IDLE && enable_i) begin
                        tick_cnt_q <= '0;
                        state_q    <= RX_START;
                    end
                end

                RX_START: begin
                    // Half a bit later the start bit is checked once more
                    if (ov_baud_rt_i && tick_cnt_q == TICK_W'(MID_SAMPLE)) begin
                        tick_cnt_q <= '0;
                        bit_cnt_q  <= '0;
                        stop_cnt_q <= 1'b0;
                        stop_ok_q  <= 1'b1;
                        // A glitch that is already gone is not a frame
                        if (rx_i == RX_LINE_IDLE) begin
                            state_q <= RX_IDLE;
                        end else begin
                            state_q <= RX_SAMPLE;
                        end
                    end
                end

                RX_SAMPLE: begin
                    if (bit_end) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == last_bit) begin
                            state_q <= parity_mode_i[1] ? RX_STOP : RX_PARITY;
                        end
                    end
                end

                RX_PARITY: begin
                    if (bit_end) begin
                        state_q <= RX_STOP;
                    end
                end

                RX_STOP: begin
                    if (bit_end) begin
                        stop_cnt_q <= 1'b1;
                        stop_ok_q  <= stop_ok_q && (rx_i == RX_LINE_IDLE);
                        if (last_stop) begin
                            state_q <= RX_IDLE;
                        end
                    end
                end

                default: begin
                    state_q <= RX_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------
    // Data path
    // ----------------------------------------

    // Bits arrive LSB first and enter at the top of the shift register
    always_ff @(posedge clk_i) begin
        if (state_q == RX_SAMPLE && bit_end) begin
            data_q <= {rx_i, data_q[7:1]};
        end
        if (state_q == RX_PARITY && bit_end) begin
            parity_q <= rx_i;
        end
    end

    // Narrow characters sit in the upper bits and need shifting down
    logic [1:0] align_shift;
    logic [7:0] data_aligned;
    logic       data_xor;

    assign align_shift  = 2'd3 - data_width_i;
    assign data_aligned = data_q >> align_shift;

    // Upper bits are zero after alignment so they do not change the XOR
    assign data_xor = ^data_aligned;

    always_comb begin
        case (parity_mode_i)
            PAR_EVEN: frame.parity_err = (parity_q != data_xor);
            PAR_ODD:  frame.parity_err = (parity_q != !data_xor);
            default:  frame.parity_err = 1'b0;
        endcase
    end

    // The frame ends in the cycle of the last stop bit sample
    assign frame.frame_done = (state_q == RX_STOP) && bit_end && last_stop;
    assign frame.data       = data_aligned;

    // A low sample on any stop bit, the current one included, is a framing error
    assign frame.frame_err = !(stop_ok_q && (rx_i == RX_LINE_IDLE));

    assign rx_idle_o = (state_q == RX_IDLE);

endmodule : rx_frame_sampler

/* logic/rx_buffer.sv */
`timescale 1ns/1ns

module rx_buffer (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        rx_fifo_read_i,
    input  logic [uart_rx_pkg::LEVEL_W-1:0] threshold_i,
    input  logic                        rx_data_stream_mode_i,
    rx_frame_if.buffer                  frame,
    output logic [7:0]                  data_rx_o,
    output logic                        frame_error_o,
    output logic                        parity_error_o,
    output logic                        overrun_error_o,
    output logic                        rx_fifo_full_o,
    output logic                        rx_fifo_empty_o,
    output logic                        rx_data_ready_o
);

    import uart_rx_pkg::*;

    // ----------------------------------------
    // Storage and pointers
    // ----------------------------------------

    logic [RX_WORD_W-1:0] mem [RX_BUF_DEPTH];
    logic [PTR_W-1:0]     wr_ptr_q;
    logic [PTR_W-1:0]     rd_ptr_q;
    logic [LEVEL_W-1:0]   level_q;

    // Characters were lost since the last stored one
    logic                 lost_q;
    logic                 ready_q;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    assign full  = (level_q == LEVEL_W'(RX_BUF_DEPTH));
    assign empty = (level_q == '0);

    // A frame arriving at a full buffer is simply dropped
    assign wr_en = frame.frame_done && !full;
    assign rd_en = rx_fifo_read_i && !empty;

    // Buffer word with the flags at their fixed positions
    logic [RX_WORD_W-1:0] wr_word;

    always_comb begin
        wr_word                 = '0;
        wr_word[7:0]            = frame.data;
        wr_word[BIT_FRAME_ERR]  = frame.frame_err;
        wr_word[BIT_PARITY_ERR] = frame.parity_err;
        wr_word[BIT_OVERRUN]    = lost_q;
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr_q] <= wr_word;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
            lost_q   <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;
            endcase
            // The flag rides on the next stored word and is then cleared
            if (frame.frame_done && full) begin
                lost_q <= 1'b1;
            end else if (wr_en) begin
                lost_q <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Data-ready pulse
    // ----------------------------------------

    // Fill level counting the frame just ended, saturating when it was dropped
    logic [LEVEL_W-1:0] level_frame;
    logic               ready_d;

    assign level_frame = full ? level_q : level_q + 1'b1;

    always_comb begin
        if (!rx_data_stream_mode_i) begin
            ready_d = frame.frame_done;
        end else if (threshold_i != '0) begin
            ready_d = frame.frame_done && (level_frame >= threshold_i);
        end else begin
            // Threshold zero waits for a completely full buffer
            ready_d = frame.frame_done && (level_frame == LEVEL_W'(RX_BUF_DEPTH));
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= ready_d;
        end
    end

    assign rx_data_ready_o = ready_q;

    // ----------------------------------------
    // Read side
    // ----------------------------------------

    // The head word falls through and is shown only during a valid read
    logic [RX_WORD_W-1:0] rd_word;
    assign rd_word = mem[rd_ptr_q];

    assign data_rx_o       = rd_en ? rd_word[7:0] : 8'h00;
    assign frame_error_o   = rd_en && rd_word[BIT_FRAME_ERR];
    assign parity_error_o  = rd_en && rd_word[BIT_PARITY_ERR];
    assign overrun_error_o = rd_en && rd_word[BIT_OVERRUN];

    // In stream mode with threshold zero the ready pulse already reports full
    assign rx_fifo_full_o  = full && !(rx_data_stream_mode_i && threshold_i == '0);
    assign rx_fifo_empty_o = empty;

endmodule : rx_buffer

/* logic/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            enable_i,
    input  logic                            ov_baud_rt_i,
    input  logic                            rx_i,
    input  logic                            rx_fifo_read_i,
    input  logic [uart_rx_pkg::LEVEL_W-1:0] threshold_i,
    input  logic                            rx_data_stream_mode_i,
    input  uart_rx_pkg::data_width_e        data_width_i,
    input  uart_rx_pkg::stop_bits_e         stop_bits_number_i,
    input  uart_rx_pkg::parity_mode_e       parity_mode_i,
    output logic [7:0]                      data_rx_o,
    output logic                            rx_data_ready_o,
    output logic                            rx_fifo_full_o,
    output logic                            rx_fifo_empty_o,
    output logic                            frame_error_o,
    output logic                            parity_error_o,
    output logic                            overrun_error_o,
    output logic                            rx_idle_o
);

    // Completed frames travel from the sampler to the buffer on this link
    rx_frame_if frame_if ();

    // Oversampling receiver for the serial line
    rx_frame_sampler sampler_inst (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .enable_i           (enable_i),
        .ov_baud_rt_i       (ov_baud_rt_i),
        .rx_i               (rx_i),
        .data_width_i       (data_width_i),
        .parity_mode_i      (parity_mode_i),
        .stop_bits_number_i (stop_bits_number_i),
        .rx_idle_o          (rx_idle_o),
        .frame              (frame_if.sampler)
    );

    // Character storage with error flags and the data-ready logic
    rx_buffer buffer_inst (
        .clk_i                 (clk_i),
        .rst_n_i               (rst_n_i),
        .rx_fifo_read_i        (rx_fifo_read_i),
        .threshold_i           (threshold_i),
        .rx_data_stream_mode_i (rx_data_stream_mode_i),
        .frame                 (frame_if.buffer),
        .data_rx_o             (data_rx_o),
        .frame_error_o         (frame_error_o),
        .parity_error_o        (parity_error_o),
        .overrun_error_o       (overrun_error_o),
        .rx_fifo_full_o        (rx_fifo_full_o),
        .rx_fifo_empty_o       (rx_fifo_empty_o),
        .rx_data_ready_o       (rx_data_ready_o)
    );

endmodule : uart_rx

/* testbench/uart_rx_checker.sv */
`timescale 1ns/1ns

module uart_rx_checker (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            rx_idle_i,
    input  logic                            rx_fifo_read_i,
    input  logic [uart_rx_pkg::LEVEL_W-1:0] threshold_i,
    input  logic                            rx_data_stream_mode_i,
    input  logic [7:0]                      data_rx_i,
    input  logic                            frame_error_i,
    input  logic                            parity_error_i,
    input  logic                            overrun_error_i,
    input  logic                            rx_fifo_full_i,
    input  logic                            rx_fifo_empty_i,
    input  logic                            rx_data_ready_i
);

    import uart_rx_pkg::*;

    int error_count = 0;

    // Frames on the line that have not ended yet, as {parity_err, frame_err, data}
    logic [9:0]  sent_q[$];

    // Model of the receive buffer, with the overrun flag in the top bit
    logic [10:0] stored_q[$];
    logic        lost_q    = 1'b0;
    logic        idle_prev = 1'b1;

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    function automatic logic [9:0] reference_frame(
        input logic [7:0]   data,
        input data_width_e  width,
        input parity_mode_e parity,
        input stop_bits_e   stops,
        input logic         flip_par,
        input logic [1:0]   bad_stop
    );
        logic [7:0] masked;
        logic       good_bit;
        logic       sent_bit;
        logic       frame_err;
        logic       parity_err;
        // Only the low 5 to 8 bits of the character travel on the line
        masked   = data & ~(8'hFF << (int'(width) + 5));
        good_bit = (parity == PAR_ODD) ? ~^masked : ^masked;
        sent_bit = good_bit ^ flip_par;
        // Parity is off whenever the upper bit of the mode is set
        parity_err = !parity[1] && (sent_bit != good_bit);
        // A low second stop bit only counts when the frame has two of them
        frame_err = bad_stop[0] || (stops == SB_2BIT && bad_stop[1]);
        return {parity_err, frame_err, masked};
    endfunction

    // Called by the stimulus when a frame starts on the line
    task note_sent_frame(
        input logic [7:0]   data,
        input data_width_e  width,
        input parity_mode_e parity,
        input stop_bits_e   stops,
        input logic         flip_par,
        input logic [1:0]   bad_stop
    );
        sent_q.push_back(reference_frame(data, width, parity, stops, flip_par, bad_stop));
    endtask

    task report_fail(input string msg);
        error_count++;
        $display("Fail at %0t ns: %s", $time, msg);
    endtask

    // ----------------------------------------
    // Comparison on the falling edge
    // ----------------------------------------

    always @(negedge clk_i) begin : compare_outputs
        logic [9:0]  sent;
        logic [10:0] head;
        logic        ready_exp;
        logic        full_exp;
        int          level;
        ready_exp = 1'b0;
        if (rst_n_i) begin
            // The receiver returns to idle in the cycle after frame_done
            if (rx_idle_i && !idle_prev) begin
                if (sent_q.size() == 0) begin
                    report_fail("a frame ended while none was on the line");
                end else begin
                    sent = sent_q.pop_front();
                    if (stored_q.size() < RX_BUF_DEPTH) begin
                        stored_q.push_back({lost_q, sent});
                        lost_q = 1'b0;
                    end else begin
                        lost_q = 1'b1;
                    end
                    level = stored_q.size();
                    if (!rx_data_stream_mode_i) begin
                        ready_exp = 1'b1;
                    end else if (threshold_i != '0) begin
                        ready_exp = (level >= int'(threshold_i));
                    end else begin
                        ready_exp = (level == RX_BUF_DEPTH);
                    end
                end
            end
            // With no frame on the line the receiver must rest in idle
            if (sent_q.size() == 0 && rx_idle_i !== 1'b1) begin
                report_fail("receiver left idle with no frame on the line");
            end
            if (rx_data_ready_i !== ready_exp) begin
                report_fail($sformatf("data ready %b, expected %b", rx_data_ready_i, ready_exp));
            end
            if (rx_fifo_empty_i !== (stored_q.size() == 0)) begin
                report_fail($sformatf("empty %b with %0d entries", rx_fifo_empty_i,
                                      stored_q.size()));
            end
            // Full is hidden in stream mode with a zero threshold
            full_exp = (stored_q.size() == RX_BUF_DEPTH) &&
                       !(rx_data_stream_mode_i && threshold_i == '0);
            if (rx_fifo_full_i !== full_exp) begin
                report_fail($sformatf("full %b, expected %b", rx_fifo_full_i, full_exp));
            end
            if (!rx_fifo_read_i) begin
                // Without a read strobe the character and flag outputs rest at zero
                if ({data_rx_i, frame_error_i, parity_error_i, overrun_error_i} !== '0) begin
                    report_fail("outputs not zero while no read is strobed");
                end
            end else if (stored_q.size() == 0) begin
                if ({data_rx_i, frame_error_i, parity_error_i, overrun_error_i} !== '0) begin
                    report_fail("outputs not zero on a read of the empty buffer");
                end
            end else begin
                head = stored_q.pop_front();
                if (data_rx_i !== head[7:0]) begin
                    report_fail($sformatf("data 0x%02h, expected 0x%02h", data_rx_i, head[7:0]));
                end
                if ({frame_error_i, parity_error_i, overrun_error_i} !==
                    {head[BIT_FRAME_ERR], head[BIT_PARITY_ERR], head[BIT_OVERRUN]}) begin
                    report_fail($sformatf("flags f/p/o %b%b%b, expected %b%b%b",
                        frame_error_i, parity_error_i, overrun_error_i,
                        head[BIT_FRAME_ERR], head[BIT_PARITY_ERR], head[BIT_OVERRUN]));
                end
            end
        end
        idle_prev = rx_idle_i;
    end

endmodule : uart_rx_checker

/* testbench/uart_rx_tb.sv */
`timescale 1ns/1ns

module uart_rx_tb;

    import uart_rx_pkg::*;

    logic               clk_i;
    logic               rst_n_i;
    logic               enable_i;
    logic               ov_baud_rt_i;
    logic               rx_i;
    logic               rx_fifo_read_i;
    logic [LEVEL_W-1:0] threshold_i;
    logic               rx_data_stream_mode_i;
    data_width_e        data_width_i;
    stop_bits_e         stop_bits_number_i;
    parity_mode_e       parity_mode_i;
    logic [7:0]         data_rx_o;
    logic               rx_data_ready_o;
    logic               rx_fifo_full_o;
    logic               rx_fifo_empty_o;
    logic               frame_error_o;
    logic               parity_error_o;
    logic               overrun_error_o;
    logic               rx_idle_o;

    logic [15:0] lfsr_q;
    logic [1:0]  tick_div_q;
    int          timeout_count;
    int          test_count;
    int          failed_tests;
    int          errors_before;

    uart_rx uart_rx_inst (.*);

    uart_rx_checker checker_inst (
        .clk_i                 (clk_i),
        .rst_n_i               (rst_n_i),
        .rx_idle_i             (rx_idle_o),
        .rx_fifo_read_i        (rx_fifo_read_i),
        .threshold_i           (threshold_i),
        .rx_data_stream_mode_i (rx_data_stream_mode_i),
        .data_rx_i             (data_rx_o),
        .frame_error_i         (frame_error_o),
        .parity_error_i        (parity_error_o),
        .overrun_error_i       (overrun_error_o),
        .rx_fifo_full_i        (rx_fifo_full_o),
        .rx_fifo_empty_i       (rx_fifo_empty_o),
        .rx_data_ready_i       (rx_data_ready_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Baud tick at 16 times the bit rate, one clock in every four
    always @(posedge clk_i) begin
        tick_div_q   <= tick_div_q + 1'b1;
        ov_baud_rt_i <= (tick_div_q == 2'd3);
    end

    // ----------------------------------------
    // Random numbers and waits
    // ----------------------------------------

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // Each bit taken costs one LFSR step
    function automatic logic [7:0] take_bits(input int count);
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = {value[6:0], lfsr_q[0]};
        end
        return value;
    endfunction

    task note_timeout(input string what);
        timeout_count++;
        $display("Timeout while waiting for %s", what);
    endtask

    task wait_ticks(input int count);
        int ticks;
        int cycles;
        ticks  = 0;
        cycles = 0;
        while (ticks < count && cycles < count * 8 + 16) begin
            @(posedge clk_i);
            cycles++;
            if (ov_baud_rt_i) begin
                ticks++;
            end
        end
        if (ticks < count) begin
            note_timeout("the baud tick");
        end
    endtask

    task wait_idle();
        int cycles;
        cycles = 0;
        while (!rx_idle_o && cycles < 2000) begin
            @(posedge clk_i);
            cycles++;
        end
        if (!rx_idle_o) begin
            note_timeout("the receiver to go idle");
        end
    endtask

    // ----------------------------------------
    // Serial frames and reads
    // ----------------------------------------

    task send_frame(
        input logic [7:0]   data,
        input data_width_e  width,
        input parity_mode_e parity,
        input stop_bits_e   stops,
        input logic         flip_par,
        input logic [1:0]   bad_stop
    );
        int         nbits;
        logic [7:0] masked;
        logic       par_bit;
        nbits   = int'(width) + 5;
        masked  = data & ((8'h01 << nbits) - 8'h01);
        par_bit = ^masked ^ (parity == PAR_ODD) ^ flip_par;
        @(posedge clk_i);
        data_width_i       <= width;
        parity_mode_i      <= parity;
        stop_bits_number_i <= stops;
        checker_inst.note_sent_frame(data, width, parity, stops, flip_par, bad_stop);
        rx_i <= 1'b0;
        wait_ticks(16);
        // Data goes out LSB first
        for (int i = 0; i < nbits; i++) begin
            rx_i <= data[i];
            wait_ticks(16);
        end
        if (!parity[1]) begin
            rx_i <= par_bit;
            wait_ticks(16);
        end
        rx_i <= !bad_stop[0];
        wait_ticks(16);
        if (stops == SB_2BIT) begin
            rx_i <= !bad_stop[1];
            wait_ticks(16);
        end
        rx_i <= 1'b1;
        wait_ticks(4);
        wait_idle();
    endtask

    task read_entries(input int count);
        @(posedge clk_i);
        rx_fifo_read_i <= 1'b1;
        repeat (count) @(posedge clk_i);
        rx_fifo_read_i <= 1'b0;
    endtask

    // Reads until empty, the last strobe lands on an empty buffer
    task drain_buffer();
        int cycles;
        cycles = 0;
        @(posedge clk_i);
        rx_fifo_read_i <= 1'b1;
        do begin
            @(posedge clk_i);
            cycles++;
        end while (!rx_fifo_empty_o && cycles < 64);
        rx_fifo_read_i <= 1'b0;
        if (!rx_fifo_empty_o) begin
            note_timeout("the buffer to run empty");
        end
    endtask

    task end_test(input string name);
        int problems;
        test_count++;
        problems      = checker_inst.error_count + timeout_count - errors_before;
        errors_before = checker_inst.error_count + timeout_count;
        if (problems == 0) begin
            $display("Test %0d %s: passed", test_count, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: failed with %0d problems", test_count, name, problems);
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin : main
        parity_mode_e pmode;
        rst_n_i               = 1'b0;
        enable_i              = 1'b0;
        ov_baud_rt_i          = 1'b0;
        rx_i                  = 1'b1;
        rx_fifo_read_i        = 1'b0;
        threshold_i           = '0;
        rx_data_stream_mode_i = 1'b0;
        data_width_i          = DW_8BIT;
        stop_bits_number_i    = SB_1BIT;
        parity_mode_i         = PAR_NONE;
        tick_div_q            = 2'd0;
        lfsr_q                = 16'd64808;
        timeout_count         = 0;
        test_count            = 0;
        failed_tests          = 0;
        errors_before         = 0;
        repeat (2) @(posedge clk_i);
        rst_n_i  <= 1'b1;
        enable_i <= 1'b1;

        for (int w = 0; w < 4; w++) begin
            repeat (3) send_frame(take_bits(8), data_width_e'(w), PAR_NONE, SB_1BIT, 1'b0, 2'b00);
        end
        drain_buffer();
        end_test("data widths");

        // Every other frame carries a flipped parity bit
        for (int i = 0; i < 10; i++) begin
            pmode = take_bits(1) ? PAR_ODD : PAR_EVEN;
            send_frame(take_bits(8), data_width_e'(take_bits(2)), pmode, SB_2BIT, i[0], 2'b00);
        end
        drain_buffer();
        end_test("parity");

        for (int i = 0; i < 4; i++) begin
            send_frame(take_bits(8), DW_8BIT, PAR_NONE, SB_2BIT, 1'b0, {1'b0, i == 1});
        end
        drain_buffer();
        end_test("stop bit");

        repeat (3) send_frame(take_bits(8), DW_8BIT, PAR_NONE, SB_1BIT, 1'b0, 2'b00);
        drain_buffer();
        @(posedge clk_i);
        rx_data_stream_mode_i <= 1'b1;
        threshold_i           <= LEVEL_W'(4);
        repeat (6) send_frame(take_bits(8), DW_5BIT, PAR_NONE, SB_1BIT, 1'b0, 2'b00);
        drain_buffer();
        @(posedge clk_i);
        threshold_i <= '0;
        repeat (32) send_frame(take_bits(8), DW_5BIT, PAR_NONE, SB_1BIT, 1'b0, 2'b00);
        drain_buffer();
        @(posedge clk_i);
        rx_data_stream_mode_i <= 1'b0;
        end_test("data ready");

        // Two frames are lost, the first write after reads carries overrun
        repeat (34) send_frame(take_bits(8), DW_5BIT, PAR_NONE, SB_1BIT, 1'b0, 2'b00);
        read_entries(2);
        send_frame(take_bits(8), DW_6BIT, PAR_NONE, SB_1BIT, 1'b0, 2'b00);
        drain_buffer();
        end_test("overrun");

        $display("Summary: %0d tests, %0d failed, %0d check failures, %0d timeouts",
                 test_count, failed_tests, checker_inst.error_count, timeout_count);
        if (checker_inst.error_count == 0 && timeout_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : uart_rx_tb

/* compile.f */
logic/uart_rx_pkg.sv
logic/rx_frame_if.sv
logic/rx_frame_sampler.sv
logic/rx_buffer.sv
logic/uart_rx.sv
testbench/uart_rx_checker.sv
testbench/uart_rx_tb.sv
